// File: ex_defs.svh
`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

// datapath widths
`define EX_XLEN        64
`define EX_INST_W      32
`define EX_REG_ADDR_W  5

// flow control
`define EX_QUEUE_DEPTH 4   // result queue entries, also upstream credits at reset
`define EX_OUT_CREDITS 2   // credits toward downstream at reset
`define EX_CREDIT_W    3

// major opcodes, inst[6:0]
`define EX_OPC_OP_IMM   7'b0010011
`define EX_OPC_OP_IMM_W 7'b0011011
`define EX_OPC_OP       7'b0110011
`define EX_OPC_OP_W     7'b0111011
`define EX_OPC_BRANCH   7'b1100011
`define EX_OPC_JAL      7'b1101111
`define EX_OPC_JALR     7'b1100111
`define EX_OPC_LUI      7'b0110111
`define EX_OPC_AUIPC    7'b0010111

// alu funct3
`define EX_F3_ADD_SUB  3'b000
`define EX_F3_SLL      3'b001
`define EX_F3_SLT      3'b010
`define EX_F3_SLTU     3'b011
`define EX_F3_XOR      3'b100
`define EX_F3_SR       3'b101   // srl and sra, split by inst[30]
`define EX_F3_OR       3'b110
`define EX_F3_AND      3'b111

// branch funct3
`define EX_F3_BEQ      3'b000
`define EX_F3_BNE      3'b001
`define EX_F3_BLT      3'b100
`define EX_F3_BGE      3'b101
`define EX_F3_BLTU     3'b110
`define EX_F3_BGEU     3'b111

`endif

// File: ex_pkg.sv
`default_nettype none

`include "ex_defs.svh"

package ex_pkg;

    typedef logic [`EX_XLEN-1:0]       xlen_t;
    typedef logic [`EX_INST_W-1:0]     inst_t;
    typedef logic [`EX_REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`EX_CREDIT_W-1:0]   credit_cnt_t;

    // operation picked by decode
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B   // lui and anything not executed
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_LTU,
        BR_GEU
    } br_cond_e;

endpackage

`default_nettype wire

// File: ex_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_defs.svh"

module ex_decode import ex_pkg::*; (
    input  wire        clk,
    input  wire        rst_n_i,
    input  wire        in_valid_i,
    input  inst_t      inst_i,
    input  xlen_t      inst_addr_i,
    input  xlen_t      op1_i,
    input  xlen_t      op2_i,
    input  xlen_t      base_addr_i,
    input  xlen_t      offset_addr_i,
    input  reg_addr_t  rd_addr_i,
    output logic       dec_valid_o,
    output alu_op_e    alu_op_o,
    output logic       word_o,
    output br_cond_e   br_cond_o,
    output logic       rd_wen_o,
    output logic       jump_o,
    output xlen_t      op1_o,
    output xlen_t      op2_o,
    output xlen_t      base_addr_o,
    output xlen_t      offset_addr_o,
    output xlen_t      inst_addr_o,
    output reg_addr_t  rd_addr_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;        // inst[30] picks sub and sra
    logic       m_ext;      // inst[25] marks mul/div which are not executed here
    logic       w_f3_ok;    // W forms only have add/sub, sll, sr
    alu_op_e    op_d;
    br_cond_e   br_d;
    logic       word_d;
    logic       wen_d;
    logic       jump_d;

    assign opcode  = inst_i[6:0];
    assign funct3  = inst_i[14:12];
    assign alt     = inst_i[30];
    assign m_ext   = inst_i[25];
    assign w_f3_ok = (funct3 == `EX_F3_ADD_SUB) || (funct3 == `EX_F3_SLL)
                     || (funct3 == `EX_F3_SR);

    function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic use_alt);
        case (f3)
            `EX_F3_ADD_SUB: alu_sel = use_alt ? ALU_SUB : ALU_ADD;
            `EX_F3_SLL:     alu_sel = ALU_SLL;
            `EX_F3_SLT:     alu_sel = ALU_SLT;
            `EX_F3_SLTU:    alu_sel = ALU_SLTU;
            `EX_F3_XOR:     alu_sel = ALU_XOR;
            `EX_F3_SR:      alu_sel = use_alt ? ALU_SRA : ALU_SRL;
            `EX_F3_OR:      alu_sel = ALU_OR;
            default:        alu_sel = ALU_AND;
        endcase
    endfunction

    always_comb begin
        op_d   = ALU_PASS_B;
        br_d   = BR_NONE;
        word_d = 1'b0;
        wen_d  = 1'b0;
        jump_d = 1'b0;
        case (opcode)
            `EX_OPC_OP_IMM: begin
                op_d  = alu_sel(funct3, alt && (funct3 == `EX_F3_SR)); // addi never subtracts
                wen_d = 1'b1;
            end
            `EX_OPC_OP: begin
                op_d  = alu_sel(funct3, alt);
                wen_d = !m_ext;
            end
            `EX_OPC_OP_IMM_W: begin
                op_d   = alu_sel(funct3, alt && (funct3 == `EX_F3_SR));
                word_d = 1'b1;
                wen_d  = w_f3_ok;
            end
            `EX_OPC_OP_W: begin
                op_d   = alu_sel(funct3, alt);
                word_d = 1'b1;
                wen_d  = w_f3_ok && !m_ext;
            end
            `EX_OPC_BRANCH: begin
                case (funct3)
                    `EX_F3_BEQ:  br_d = BR_EQ;
                    `EX_F3_BNE:  br_d = BR_NE;
                    `EX_F3_BLT:  br_d = BR_LT;
                    `EX_F3_BGE:  br_d = BR_GE;
                    `EX_F3_BLTU: br_d = BR_LTU;
                    `EX_F3_BGEU: br_d = BR_GEU;
                    default:     br_d = BR_NONE;
                endcase
            end
            `EX_OPC_JAL, `EX_OPC_JALR: begin
                op_d   = ALU_ADD;   // link value comes in as op1 + op2
                wen_d  = 1'b1;
                jump_d = 1'b1;
            end
            `EX_OPC_LUI:   wen_d = 1'b1;
            `EX_OPC_AUIPC: begin
                op_d  = ALU_ADD;
                wen_d = 1'b1;
            end
            default: ;              // result goes out with no side effects
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            dec_valid_o <= 1'b0;
        end else begin
            dec_valid_o <= in_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid_i) begin
            alu_op_o      <= op_d;
            word_o        <= word_d;
            br_cond_o     <= br_d;
            rd_wen_o      <= wen_d;
            jump_o        <= jump_d;
            op1_o         <= op1_i;
            op2_o         <= op2_i;
            base_addr_o   <= base_addr_i;
            offset_addr_o <= offset_addr_i;
            inst_addr_o   <= inst_addr_i;
            rd_addr_o     <= rd_addr_i;
        end
    end

    // an accepted instruction must decode to known controls
    a_inst_known: assert property (@(posedge clk) disable iff (!rst_n_i)
        in_valid_i |-> !$isunknown(inst_i));

endmodule

`default_nettype wire

// File: ex_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_defs.svh"

module ex_alu import ex_pkg::*; (
    input  wire        clk,
    input  wire        rst_n_i,
    input  wire        dec_valid_i,
    input  alu_op_e    alu_op_i,
    input  wire        word_i,
    input  br_cond_e   br_cond_i,
    input  wire        rd_wen_i,
    input  wire        jump_i,
    input  xlen_t      op1_i,
    input  xlen_t      op2_i,
    input  xlen_t      base_addr_i,
    input  xlen_t      offset_addr_i,
    input  xlen_t      inst_addr_i,
    input  reg_addr_t  rd_addr_i,
    output logic       alu_valid_o,
    output xlen_t      rd_wdata_o,
    output reg_addr_t  rd_waddr_o,
    output logic       reg_wen_o,
    output logic       jump_en_o,
    output xlen_t      jump_addr_o,
    output xlen_t      inst_addr_o
);

    logic [5:0] shamt;
    xlen_t      op1_srl;    // zero-extended low word for srlw
    xlen_t      op1_sra;    // sign-extended low word for sraw
    xlen_t      raw;
    xlen_t      result;
    xlen_t      target;
    logic       eq;
    logic       lt;
    logic       ltu;
    logic       taken;

    assign shamt   = word_i ? {1'b0, op2_i[4:0]} : op2_i[5:0];
    assign op1_srl = word_i ? {32'b0, op1_i[31:0]} : op1_i;
    assign op1_sra = word_i ? {{32{op1_i[31]}}, op1_i[31:0]} : op1_i;
    assign eq      = (op1_i == op2_i);
    assign lt      = ($signed(op1_i) < $signed(op2_i));
    assign ltu     = (op1_i < op2_i);
    assign target  = base_addr_i + offset_addr_i;

    always_comb begin
        case (alu_op_i)
            ALU_ADD:  raw = op1_i + op2_i;
            ALU_SUB:  raw = op1_i - op2_i;
            ALU_SLL:  raw = op1_i << shamt;
            ALU_SLT:  raw = {63'b0, lt};
            ALU_SLTU: raw = {63'b0, ltu};
            ALU_XOR:  raw = op1_i ^ op2_i;
            ALU_SRL:  raw = op1_srl >> shamt;
            ALU_SRA:  raw = $signed(op1_sra) >>> shamt;
            ALU_OR:   raw = op1_i | op2_i;
            ALU_AND:  raw = op1_i & op2_i;
            default:  raw = op2_i;  // pass b
        endcase
    end

    assign result = word_i ? {{32{raw[31]}}, raw[31:0]} : raw;

    always_comb begin
        case (br_cond_i)
            BR_EQ:   taken = eq;
            BR_NE:   taken = !eq;
            BR_LT:   taken = lt;
            BR_GE:   taken = !lt;
            BR_LTU:  taken = ltu;
            BR_GEU:  taken = !ltu;
            default: taken = 1'b0;
        endcase
    end

    // flags are qualified by valid so a bubble never looks like a jump
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            alu_valid_o <= 1'b0;
            reg_wen_o   <= 1'b0;
            jump_en_o   <= 1'b0;
        end else begin
            alu_valid_o <= dec_valid_i;
            reg_wen_o   <= dec_valid_i && rd_wen_i;
            jump_en_o   <= dec_valid_i && (jump_i || taken);
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid_i) begin
            rd_wdata_o  <= result;
            rd_waddr_o  <= rd_addr_i;
            jump_addr_o <= (jump_i || taken) ? target : '0;
            inst_addr_o <= inst_addr_i;
        end
    end

    // jal and jalr always link and never carry a branch condition
    a_jump_is_link: assert property (@(posedge clk) disable iff (!rst_n_i)
        (dec_valid_i && jump_i) |-> (rd_wen_i && (br_cond_i == BR_NONE)));

endmodule

`default_nettype wire

// File: ex_result.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_defs.svh"

module ex_result import ex_pkg::*; (
    input  wire        clk,
    input  wire        rst_n_i,
    input  wire        alu_valid_i,
    input  xlen_t      rd_wdata_i,
    input  reg_addr_t  rd_waddr_i,
    input  wire        reg_wen_i,
    input  wire        jump_en_i,
    input  xlen_t      jump_addr_i,
    input  xlen_t      inst_addr_i,
    input  wire        out_credit_i,
    output logic       out_valid_o,
    output logic       in_credit_o,
    output xlen_t      rd_wdata_o,
    output reg_addr_t  rd_waddr_o,
    output logic       reg_wen_o,
    output logic       jump_en_o,
    output xlen_t      jump_addr_o,
    output xlen_t      inst_addr_o
);

    localparam int PTR_W = $clog2(`EX_QUEUE_DEPTH);

    xlen_t       wdata_mem [`EX_QUEUE_DEPTH];
    reg_addr_t   waddr_mem [`EX_QUEUE_DEPTH];
    logic        wen_mem   [`EX_QUEUE_DEPTH];
    logic        jump_mem  [`EX_QUEUE_DEPTH];
    xlen_t       jaddr_mem [`EX_QUEUE_DEPTH];
    xlen_t       pc_mem    [`EX_QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    credit_cnt_t      count_q;      // entries held
    credit_cnt_t      credit_q;     // credits toward downstream
    logic             from_mem;     // head comes from storage, else straight from alu
    logic             pop;
    logic             pop_mem;
    logic             push;

    assign from_mem = (count_q != '0);
    assign pop      = (from_mem || alu_valid_i) && (credit_q != '0);
    assign pop_mem  = pop && from_mem;
    assign push     = alu_valid_i && !(pop && !from_mem);  // empty queue bypass

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            credit_q <= credit_cnt_t'(`EX_OUT_CREDITS);
        end else begin
            if (push) wr_ptr_q <= wr_ptr_q + PTR_W'(1);
            if (pop_mem) rd_ptr_q <= rd_ptr_q + PTR_W'(1);
            count_q  <= count_q + credit_cnt_t'(push) - credit_cnt_t'(pop_mem);
            credit_q <= credit_q - credit_cnt_t'(pop) + credit_cnt_t'(out_credit_i);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            wdata_mem[wr_ptr_q] <= rd_wdata_i;
            waddr_mem[wr_ptr_q] <= rd_waddr_i;
            wen_mem[wr_ptr_q]   <= reg_wen_i;
            jump_mem[wr_ptr_q]  <= jump_en_i;
            jaddr_mem[wr_ptr_q] <= jump_addr_i;
            pc_mem[wr_ptr_q]    <= inst_addr_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            out_valid_o <= 1'b0;
            in_credit_o <= 1'b0;
            reg_wen_o   <= 1'b0;
            jump_en_o   <= 1'b0;
        end else begin
            out_valid_o <= pop;
            in_credit_o <= pop;     // one upstream credit per result leaving
            reg_wen_o   <= pop && (from_mem ? wen_mem[rd_ptr_q] : reg_wen_i);
            jump_en_o   <= pop && (from_mem ? jump_mem[rd_ptr_q] : jump_en_i);
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            rd_wdata_o  <= from_mem ? wdata_mem[rd_ptr_q] : rd_wdata_i;
            rd_waddr_o  <= from_mem ? waddr_mem[rd_ptr_q] : rd_waddr_i;
            jump_addr_o <= from_mem ? jaddr_mem[rd_ptr_q] : jump_addr_i;
            inst_addr_o <= from_mem ? pc_mem[rd_ptr_q] : inst_addr_i;
        end
    end

    // upstream credits bound everything in flight to the queue depth
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n_i)
        push |-> (count_q < `EX_QUEUE_DEPTH));

    a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n_i)
        credit_q <= `EX_OUT_CREDITS);

endmodule

`default_nettype wire

// File: ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_defs.svh"

module ex_stage import ex_pkg::*; (
    input  wire        clk,
    input  wire        rst_n_i,
    // upstream
    input  wire        in_valid_i,
    input  inst_t      inst_i,
    input  xlen_t      inst_addr_i,
    input  xlen_t      op1_i,
    input  xlen_t      op2_i,
    input  xlen_t      base_addr_i,
    input  xlen_t      offset_addr_i,
    input  reg_addr_t  rd_addr_i,
    output logic       in_credit_o,
    // downstream
    output logic       out_valid_o,
    output xlen_t      rd_wdata_o,
    output reg_addr_t  rd_waddr_o,
    output logic       reg_wen_o,
    output logic       jump_en_o,
    output xlen_t      jump_addr_o,
    output xlen_t      inst_addr_o,
    input  wire        out_credit_i
);

    // decode to alu
    logic       dec_valid;
    alu_op_e    dec_op;
    logic       dec_word;
    br_cond_e   dec_br;
    logic       dec_wen;
    logic       dec_jump;
    xlen_t      dec_op1;
    xlen_t      dec_op2;
    xlen_t      dec_base;
    xlen_t      dec_offset;
    xlen_t      dec_pc;
    reg_addr_t  dec_rd;

    // alu to result queue
    logic       alu_valid;
    xlen_t      alu_wdata;
    reg_addr_t  alu_waddr;
    logic       alu_wen;
    logic       alu_jump;
    xlen_t      alu_jaddr;
    xlen_t      alu_pc;

    ex_decode u_decode (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .in_valid_i    (in_valid_i),
        .inst_i        (inst_i),
        .inst_addr_i   (inst_addr_i),
        .op1_i         (op1_i),
        .op2_i         (op2_i),
        .base_addr_i   (base_addr_i),
        .offset_addr_i (offset_addr_i),
        .rd_addr_i     (rd_addr_i),
        .dec_valid_o   (dec_valid),
        .alu_op_o      (dec_op),
        .word_o        (dec_word),
        .br_cond_o     (dec_br),
        .rd_wen_o      (dec_wen),
        .jump_o        (dec_jump),
        .op1_o         (dec_op1),
        .op2_o         (dec_op2),
        .base_addr_o   (dec_base),
        .offset_addr_o (dec_offset),
        .inst_addr_o   (dec_pc),
        .rd_addr_o     (dec_rd)
    );

    ex_alu u_alu (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .dec_valid_i   (dec_valid),
        .alu_op_i      (dec_op),
        .word_i        (dec_word),
        .br_cond_i     (dec_br),
        .rd_wen_i      (dec_wen),
        .jump_i        (dec_jump),
        .op1_i         (dec_op1),
        .op2_i         (dec_op2),
        .base_addr_i   (dec_base),
        .offset_addr_i (dec_offset),
        .inst_addr_i   (dec_pc),
        .rd_addr_i     (dec_rd),
        .alu_valid_o   (alu_valid),
        .rd_wdata_o    (alu_wdata),
        .rd_waddr_o    (alu_waddr),
        .reg_wen_o     (alu_wen),
        .jump_en_o     (alu_jump),
        .jump_addr_o   (alu_jaddr),
        .inst_addr_o   (alu_pc)
    );

    ex_result u_result (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .alu_valid_i   (alu_valid),
        .rd_wdata_i    (alu_wdata),
        .rd_waddr_i    (alu_waddr),
        .reg_wen_i     (alu_wen),
        .jump_en_i     (alu_jump),
        .jump_addr_i   (alu_jaddr),
        .inst_addr_i   (alu_pc),
        .out_credit_i  (out_credit_i),
        .out_valid_o   (out_valid_o),
        .in_credit_o   (in_credit_o),
        .rd_wdata_o    (rd_wdata_o),
        .rd_waddr_o    (rd_waddr_o),
        .reg_wen_o     (reg_wen_o),
        .jump_en_o     (jump_en_o),
        .jump_addr_o   (jump_addr_o),
        .inst_addr_o   (inst_addr_o)
    );

endmodule

`default_nettype wire

// File: tb_ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_defs.svh"

module tb_ex_stage import ex_pkg::*; ();

    localparam int    MAX_ROWS   = 48;
    localparam int    WAIT_LIMIT = 200;    // cycles per wait
    localparam xlen_t BASE       = 64'h0000_0000_8000_1000;
    localparam xlen_t OFF        = 64'h0000_0000_0000_0040;
    localparam xlen_t TGT        = 64'h0000_0000_8000_1040;   // BASE + OFF
    localparam xlen_t NEG5       = 64'hFFFF_FFFF_FFFF_FFFB;
    localparam xlen_t ALL1       = 64'hFFFF_FFFF_FFFF_FFFF;

    logic       clk;
    logic       rst_n_i;
    logic       in_valid_i;
    inst_t      inst_i;
    xlen_t      inst_addr_i;
    xlen_t      op1_i;
    xlen_t      op2_i;
    xlen_t      base_addr_i;
    xlen_t      offset_addr_i;
    reg_addr_t  rd_addr_i;
    logic       in_credit_o;
    logic       out_valid_o;
    xlen_t      rd_wdata_o;
    reg_addr_t  rd_waddr_o;
    logic       reg_wen_o;
    logic       jump_en_o;
    xlen_t      jump_addr_o;
    xlen_t      inst_addr_o;
    logic       out_credit_i;

    // stimulus and expected values
    string row_name  [MAX_ROWS];
    inst_t row_inst  [MAX_ROWS];
    xlen_t row_op1   [MAX_ROWS];
    xlen_t row_op2   [MAX_ROWS];
    xlen_t row_base  [MAX_ROWS];
    xlen_t row_off   [MAX_ROWS];
    xlen_t row_wdata [MAX_ROWS];
    logic  row_wen   [MAX_ROWS];
    logic  row_jump  [MAX_ROWS];
    xlen_t row_jaddr [MAX_ROWS];
    int    num_rows;

    int     sent;              // rows driven upstream
    int     in_credits_seen;
    int     recv_count;
    int     credits_given;     // credits handed back downstream
    int     credit_delay;
    int     cyc;
    int     last_in_cyc;
    int     mismatches;
    int     other_errors;
    int     checked;
    logic   stress;            // random credit hold-off, no latency check
    logic   timeout_hit;
    integer rand_seed;

    ex_stage u_ex_stage (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .in_valid_i    (in_valid_i),
        .inst_i        (inst_i),
        .inst_addr_i   (inst_addr_i),
        .op1_i         (op1_i),
        .op2_i         (op2_i),
        .base_addr_i   (base_addr_i),
        .offset_addr_i (offset_addr_i),
        .rd_addr_i     (rd_addr_i),
        .in_credit_o   (in_credit_o),
        .out_valid_o   (out_valid_o),
        .rd_wdata_o    (rd_wdata_o),
        .rd_waddr_o    (rd_waddr_o),
        .reg_wen_o     (reg_wen_o),
        .jump_en_o     (jump_en_o),
        .jump_addr_o   (jump_addr_o),
        .inst_addr_o   (inst_addr_o),
        .out_credit_i  (out_credit_i)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic inst_t encode_inst(input logic [6:0] opc, input logic [2:0] f3,
                                          input logic alt);
        inst_t i;
        i        = '0;
        i[6:0]   = opc;
        i[14:12] = f3;
        i[30]    = alt;
        return i;
    endfunction

    function automatic xlen_t row_pc(input int idx);
        return 64'h0000_0000_0001_0000 + xlen_t'(idx * 4);
    endfunction

    function automatic reg_addr_t row_rd(input int idx);
        return reg_addr_t'(idx % 31 + 1);
    endfunction

    task automatic add_row(input string name, input inst_t inst, input xlen_t op1,
                           input xlen_t op2, input xlen_t base, input xlen_t off,
                           input xlen_t wdata, input logic wen, input logic jump,
                           input xlen_t jaddr);
        row_name[num_rows]  = name;
        row_inst[num_rows]  = inst;
        row_op1[num_rows]   = op1;
        row_op2[num_rows]   = op2;
        row_base[num_rows]  = base;
        row_off[num_rows]   = off;
        row_wdata[num_rows] = wdata;
        row_wen[num_rows]   = wen;
        row_jump[num_rows]  = jump;
        row_jaddr[num_rows] = jaddr;
        num_rows++;
    endtask

    // writes rd, no jump
    task automatic alu_row(input string name, input inst_t inst, input xlen_t op1,
                           input xlen_t op2, input xlen_t wdata);
        add_row(name, inst, op1, op2, BASE, OFF, wdata, 1'b1, 1'b0, '0);
    endtask

    task automatic branch_row(input string name, input logic [2:0] f3, input xlen_t op1,
                              input xlen_t op2, input logic taken);
        add_row(name, encode_inst(`EX_OPC_BRANCH, f3, 1'b0), op1, op2, BASE, OFF,
                '0, 1'b0, taken, taken ? TGT : '0);
    endtask

    task automatic load_table;
        num_rows = 0;
        alu_row("add", encode_inst(`EX_OPC_OP, `EX_F3_ADD_SUB, 1'b0), 5, 7, 12);
        alu_row("sub", encode_inst(`EX_OPC_OP, `EX_F3_ADD_SUB, 1'b1), 5, 7,
                64'hFFFF_FFFF_FFFF_FFFE);
        alu_row("addi", encode_inst(`EX_OPC_OP_IMM, `EX_F3_ADD_SUB, 1'b0), 64'h1000, ALL1,
                64'hFFF);
        alu_row("slt", encode_inst(`EX_OPC_OP, `EX_F3_SLT, 1'b0), ALL1, 1, 1);
        alu_row("sltu", encode_inst(`EX_OPC_OP, `EX_F3_SLTU, 1'b0), ALL1, 1, 0);
        alu_row("slti", encode_inst(`EX_OPC_OP_IMM, `EX_F3_SLT, 1'b0), 3, NEG5, 0);
        alu_row("sltiu", encode_inst(`EX_OPC_OP_IMM, `EX_F3_SLTU, 1'b0), 3, NEG5, 1);
        alu_row("xori", encode_inst(`EX_OPC_OP_IMM, `EX_F3_XOR, 1'b0),
                64'hFF00_FF00_FF00_FF00, 64'h0F0F_0F0F_0F0F_0F0F, 64'hF00F_F00F_F00F_F00F);
        alu_row("or", encode_inst(`EX_OPC_OP, `EX_F3_OR, 1'b0), 64'hF0, 64'h0F, 64'hFF);
        alu_row("andi", encode_inst(`EX_OPC_OP_IMM, `EX_F3_AND, 1'b0), 64'hFF00, 64'h0FF0,
                64'h0F00);
        alu_row("sll", encode_inst(`EX_OPC_OP, `EX_F3_SLL, 1'b0), 1, 64'h44, 64'h10);
        alu_row("slli_63", encode_inst(`EX_OPC_OP_IMM, `EX_F3_SLL, 1'b0), 1, 63,
                64'h8000_0000_0000_0000);
        alu_row("srl", encode_inst(`EX_OPC_OP, `EX_F3_SR, 1'b0), 64'h8000_0000_0000_0000, 4,
                64'h0800_0000_0000_0000);
        alu_row("sra", encode_inst(`EX_OPC_OP, `EX_F3_SR, 1'b1), 64'h8000_0000_0000_0000, 4,
                64'hF800_0000_0000_0000);
        alu_row("srai", encode_inst(`EX_OPC_OP_IMM, `EX_F3_SR, 1'b1),
                64'hFFFF_FFFF_FFFF_FF00, 8, ALL1);
        // word forms, low 32 bits sign-extended
        alu_row("addw_ovf", encode_inst(`EX_OPC_OP_W, `EX_F3_ADD_SUB, 1'b0), 64'h7FFF_FFFF, 1,
                64'hFFFF_FFFF_8000_0000);
        alu_row("subw", encode_inst(`EX_OPC_OP_W, `EX_F3_ADD_SUB, 1'b1), 0, 1, ALL1);
        alu_row("addiw", encode_inst(`EX_OPC_OP_IMM_W, `EX_F3_ADD_SUB, 1'b0),
                64'hABCD_0000_0000_0005, 3, 64'h8);
        alu_row("sllw", encode_inst(`EX_OPC_OP_W, `EX_F3_SLL, 1'b0), 1, 64'h3F,
                64'hFFFF_FFFF_8000_0000);
        alu_row("srlw", encode_inst(`EX_OPC_OP_W, `EX_F3_SR, 1'b0), 64'hFFFF_FFFF_8000_0000,
                64'h24, 64'h0800_0000);
        alu_row("sraw", encode_inst(`EX_OPC_OP_W, `EX_F3_SR, 1'b1), 64'hFFFF_FFFF_8000_0000,
                64'h24, 64'hFFFF_FFFF_F800_0000);
        alu_row("sraiw", encode_inst(`EX_OPC_OP_IMM_W, `EX_F3_SR, 1'b1), 64'h8000_0000, 31,
                ALL1);
        branch_row("beq_t", `EX_F3_BEQ, 7, 7, 1'b1);
        branch_row("beq_n", `EX_F3_BEQ, 7, 8, 1'b0);
        branch_row("bne_t", `EX_F3_BNE, 7, 8, 1'b1);
        branch_row("bne_n", `EX_F3_BNE, 7, 7, 1'b0);
        branch_row("blt_t", `EX_F3_BLT, NEG5, 3, 1'b1);
        branch_row("blt_n", `EX_F3_BLT, 3, NEG5, 1'b0);
        branch_row("bge_t", `EX_F3_BGE, 3, NEG5, 1'b1);
        branch_row("bge_n", `EX_F3_BGE, NEG5, 3, 1'b0);
        branch_row("bltu_t", `EX_F3_BLTU, 3, NEG5, 1'b1);
        branch_row("bltu_n", `EX_F3_BLTU, NEG5, 3, 1'b0);
        branch_row("bgeu_t", `EX_F3_BGEU, NEG5, 3, 1'b1);
        branch_row("bgeu_n", `EX_F3_BGEU, 3, NEG5, 1'b0);
        add_row("jal", encode_inst(`EX_OPC_JAL, 3'b000, 1'b0), 64'h2000, 4, BASE, OFF,
                64'h2004, 1'b1, 1'b1, TGT);
        add_row("jalr", encode_inst(`EX_OPC_JALR, 3'b000, 1'b0), 64'h3000, 4,
                64'h8000_0000_0000_0010, 64'hFFFF_FFFF_FFFF_FFF0, 64'h3004, 1'b1, 1'b1,
                64'h8000_0000_0000_0000);
        alu_row("lui", encode_inst(`EX_OPC_LUI, 3'b000, 1'b0), 64'h1234,
                64'hFFFF_FFFF_ABCD_E000, 64'hFFFF_FFFF_ABCD_E000);
        alu_row("auipc", encode_inst(`EX_OPC_AUIPC, 3'b000, 1'b0), 64'h4000, 64'h12000,
                64'h16000);
        // ld and sd opcodes, no longer executed
        add_row("load", encode_inst(7'b0000011, 3'b011, 1'b0), 64'h100, 64'h8, BASE, OFF,
                '0, 1'b0, 1'b0, '0);
        add_row("store", encode_inst(7'b0100011, 3'b011, 1'b0), 64'h100, 64'h8, BASE, OFF,
                '0, 1'b0, 1'b0, '0);
    endtask

    task automatic check_xlen(input string test, input string field, input xlen_t exp,
                              input xlen_t act);
        if (act !== exp) begin
            $display("Mismatch %s %s: expected %h, actual %h", test, field, exp, act);
            mismatches++;
        end
    endtask

    task automatic check_reg_addr(input string test, input string field,
                                  input reg_addr_t exp, input reg_addr_t act);
        if (act !== exp) begin
            $display("Mismatch %s %s: expected %0d, actual %0d", test, field, exp, act);
            mismatches++;
        end
    endtask

    task automatic check_bit(input string test, input string field, input logic exp,
                             input logic act);
        if (act !== exp) begin
            $display("Mismatch %s %s: expected %b, actual %b", test, field, exp, act);
            mismatches++;
        end
    endtask

    task automatic check_result(input int idx);
        if (row_wen[idx]) begin
            check_xlen(row_name[idx], "rd_wdata", row_wdata[idx], rd_wdata_o);
        end
        check_reg_addr(row_name[idx], "rd_waddr", row_rd(idx), rd_waddr_o);
        check_bit(row_name[idx], "reg_wen", row_wen[idx], reg_wen_o);
        check_bit(row_name[idx], "jump_en", row_jump[idx], jump_en_o);
        check_xlen(row_name[idx], "jump_addr", row_jaddr[idx], jump_addr_o);
        check_xlen(row_name[idx], "inst_addr", row_pc(idx), inst_addr_o);
        checked++;
    endtask

    // called just after a rising edge, returns one edge after driving the row
    task automatic issue_row(input int idx);
        int waited;
        waited = 0;
        while (sent - in_credits_seen >= `EX_QUEUE_DEPTH && waited < WAIT_LIMIT) begin
            in_valid_i <= 1'b0;
            @(posedge clk);
            waited++;
        end
        if (sent - in_credits_seen >= `EX_QUEUE_DEPTH) begin
            $display("Timeout: no upstream credit came back before row %s", row_name[idx]);
            other_errors++;
            timeout_hit = 1'b1;
        end else begin
            in_valid_i    <= 1'b1;
            inst_i        <= row_inst[idx];
            inst_addr_i   <= row_pc(idx);
            op1_i         <= row_op1[idx];
            op2_i         <= row_op2[idx];
            base_addr_i   <= row_base[idx];
            offset_addr_i <= row_off[idx];
            rd_addr_i     <= row_rd(idx);
            sent++;
            @(posedge clk);
        end
    endtask

    task automatic wait_results(input int target);
        int waited;
        waited = 0;
        while (recv_count < target && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (recv_count < target) begin
            $display("Timeout: only %0d of %0d results arrived", recv_count, target);
            other_errors++;
            timeout_hit = 1'b1;
        end
    endtask

    task automatic finish_run;
        $display("checked %0d results: %0d mismatches, %0d other errors",
                 checked, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    // downstream receiver, hands credits back after a random hold-off
    always @(posedge clk) begin
        if (!rst_n_i) begin
            out_credit_i  <= 1'b0;
            credits_given <= 0;
            credit_delay  <= 0;
        end else begin
            out_credit_i <= 1'b0;
            if (credit_delay > 0) begin
                credit_delay <= credit_delay - 1;
            end else if (recv_count > credits_given) begin
                out_credit_i  <= 1'b1;
                credits_given <= credits_given + 1;
                credit_delay  <= stress ? ($unsigned($random(rand_seed)) % 7) : 0;
            end
        end
    end

    // outputs are sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n_i) begin
            cyc++;
            if (in_valid_i) last_in_cyc = cyc;
            if (in_credit_o) in_credits_seen++;
            if (out_valid_o) begin
                check_result(recv_count % num_rows);
                if (!stress && cyc - last_in_cyc != 3) begin
                    $display("Mismatch %s latency: expected 3, actual %0d",
                             row_name[recv_count % num_rows], cyc - last_in_cyc);
                    mismatches++;
                end
                recv_count++;
                if (recv_count > `EX_OUT_CREDITS + credits_given) begin
                    $display("Error: %0d results sent with only %0d credits returned",
                             recv_count, credits_given);
                    other_errors++;
                end
            end
        end
    end

    initial begin
        rand_seed       = 44647;
        sent            = 0;
        in_credits_seen = 0;
        recv_count      = 0;
        cyc             = 0;
        last_in_cyc     = 0;
        mismatches      = 0;
        other_errors    = 0;
        checked         = 0;
        stress          = 1'b0;
        timeout_hit     = 1'b0;
        rst_n_i         = 1'b0;
        in_valid_i      = 1'b0;
        inst_i          = '0;
        inst_addr_i     = '0;
        op1_i           = '0;
        op2_i           = '0;
        base_addr_i     = '0;
        offset_addr_i   = '0;
        rd_addr_i       = '0;
        out_credit_i    = 1'b0;
        load_table();

        repeat (4) @(posedge clk);
        rst_n_i <= 1'b1;
        @(negedge clk);
        check_bit("reset", "out_valid", 1'b0, out_valid_o);
        check_bit("reset", "in_credit", 1'b0, in_credit_o);
        check_bit("reset", "reg_wen", 1'b0, reg_wen_o);
        check_bit("reset", "jump_en", 1'b0, jump_en_o);
        @(posedge clk);

        // one row at a time, empty queue, fixed latency
        for (int i = 0; i < num_rows && !timeout_hit; i++) begin
            issue_row(i);
            in_valid_i <= 1'b0;
            wait_results(sent);
        end

        // back to back while downstream holds credits back
        stress <= 1'b1;
        for (int i = 0; i < num_rows && !timeout_hit; i++) begin
            issue_row(i);
        end
        in_valid_i <= 1'b0;
        if (!timeout_hit) wait_results(sent);

        if (!timeout_hit) begin
            if (recv_count != 2 * num_rows) begin
                $display("Error: %0d results for %0d rows issued", recv_count, 2 * num_rows);
                other_errors++;
            end
            if (in_credits_seen != recv_count) begin
                $display("Error: %0d upstream credits for %0d results",
                         in_credits_seen, recv_count);
                other_errors++;
            end
        end
        finish_run();
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+.
ex_pkg.sv
ex_decode.sv
ex_alu.sv
ex_result.sv
ex_stage.sv
tb_ex_stage.sv

// File: Bender.yml
package:
  name: ex_stage

export_include_dirs:
  - .

sources:
  - files:
      - ex_pkg.sv
      - ex_decode.sv
      - ex_alu.sv
      - ex_result.sv
      - ex_stage.sv
  - target: test
    files:
      - tb_ex_stage.sv
